/* design/beat_fifo.sv */
/*
  Synchronous FIFO with a first-word fall-through output.
  FIFO_DEPTH must be a power of two and at least 2, since the pointers wrap.
  Data has no reset; only pointers and count are cleared.
*/
module beat_fifo #(
  parameter type T          = logic,
  parameter int  FIFO_DEPTH = 4
) (
  input  logic  clk,
  input  logic  reset,
  stream_if.dst in,
  stream_if.src out
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  T                 mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             push;
  logic             pop;

  assign in.ready  = (count < FIFO_DEPTH);
  assign out.valid = (count != '0);
  assign out.data  = mem[rd_ptr];

  assign push = in.valid && in.ready;
  assign pop  = out.valid && out.ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in.data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a push must never land on an entry that has not been read yet.
  a_no_overwrite: assert property (
    @(posedge clk) disable iff (reset)
    push && (count != '0) |-> (wr_ptr != rd_ptr)
  ) else $error("beat_fifo: push into a full FIFO");

  a_count_bound: assert property (
    @(posedge clk) disable iff (reset)
    count <= FIFO_DEPTH
  ) else $error("beat_fifo: count above depth");

endmodule

/* design/conv_cfg_pkg.sv */
/*
  Kernel-width code is the width itself (1, 2 or 3). Code 0 is illegal.
  group_count takes the member count as an argument so this package
  stays free of the datapath package and compiles first.
*/
package conv_cfg_pkg;

  localparam int KW_MAX = 3;

  // two bits hold every legal width up to KW_MAX.
  typedef logic [$clog2(KW_MAX+1)-1:0] kw_t;

  // sideband flags that travel with every input beat.
  typedef struct packed {
    kw_t  kw;
    logic cin_last;
    logic last;
  } side_t;

  function automatic int unsigned kw_width(input kw_t kw);
    return int'(kw);
  endfunction

  // number of member groups that one kernel width carves out of the members.
  function automatic int unsigned group_count(input int unsigned members, input kw_t kw);
    if (kw == '0) begin
      return 0;
    end
    return members / kw_width(kw);
  endfunction

endpackage

/* design/conv_data_pkg.sv */
/*
  Datapath sizes and payload types of the convolution slice.
  Accumulators are signed and wrap at ACC_WIDTH bits.
  Depends on conv_cfg_pkg, which must be compiled first.
*/
package conv_data_pkg;

  // ========================================
  // sizes
  // ========================================
  localparam int UNITS      = 2;
  localparam int MEMBERS    = 6;
  localparam int WORD_WIDTH = 8;
  localparam int ACC_WIDTH  = 24;

  // the smallest kernel width is 1, so every member can be its own group.
  localparam int GROUPS_MAX = MEMBERS;

  // ========================================
  // types
  // ========================================
  typedef logic signed [WORD_WIDTH-1:0] word_t;
  typedef logic signed [ACC_WIDTH-1:0]  acc_t;

  typedef word_t [UNITS-1:0]   pixels_t;
  typedef word_t [MEMBERS-1:0] weights_t;

  typedef acc_t [UNITS-1:0][MEMBERS-1:0]    member_sums_t;
  typedef acc_t [UNITS-1:0][GROUPS_MAX-1:0] group_sums_t;

  typedef struct packed {
    pixels_t             pixels;
    weights_t            weights;
    conv_cfg_pkg::side_t side;
  } beat_t;

  // partial sums of one finished channel run.
  typedef struct packed {
    member_sums_t      sums;
    conv_cfg_pkg::kw_t kw;
    logic              last;
  } psum_t;

  typedef struct packed {
    group_sums_t           sums;
    logic [GROUPS_MAX-1:0] keep;
    logic                  last;
  } result_t;

endpackage

/* design/conv_engine_top.sv */
/*
  Convolution slice: input FIFO, MAC array, kernel reducer, output FIFO.
  At least four cycles from the closing beat to m_valid.
  s_kw must never be 0.
*/
module conv_engine_top (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 s_valid,
  output logic                                 s_ready,
  input  conv_data_pkg::pixels_t               s_pixels,
  input  conv_data_pkg::weights_t              s_weights,
  input  conv_cfg_pkg::kw_t                    s_kw,
  input  logic                                 s_cin_last,
  input  logic                                 s_last,
  output logic                                 m_valid,
  input  logic                                 m_ready,
  output conv_data_pkg::group_sums_t           m_data,
  output logic [conv_data_pkg::GROUPS_MAX-1:0] m_keep,
  output logic                                 m_last
);

  stream_if #(.T(conv_data_pkg::beat_t))   in_raw ();
  stream_if #(.T(conv_data_pkg::beat_t))   in_beats ();
  stream_if #(.T(conv_data_pkg::psum_t))   psums ();
  stream_if #(.T(conv_data_pkg::result_t)) results ();
  stream_if #(.T(conv_data_pkg::result_t)) out_res ();

  // ========================================
  // port packing
  // ========================================
  assign in_raw.valid = s_valid;
  assign in_raw.data  = '{
    pixels:  s_pixels,
    weights: s_weights,
    side:    '{kw: s_kw, cin_last: s_cin_last, last: s_last}
  };
  assign s_ready = in_raw.ready;

  assign m_valid       = out_res.valid;
  assign m_data        = out_res.data.sums;
  assign m_keep        = out_res.data.keep;
  assign m_last        = out_res.data.last;
  assign out_res.ready = m_ready;

  // ========================================
  // pipeline
  // ========================================
  beat_fifo #(.T(conv_data_pkg::beat_t)) in_fifo (
    .clk   (clk),
    .reset (reset),
    .in    (in_raw),
    .out   (in_beats)
  );

  conv_mac_array mac_array (
    .clk   (clk),
    .reset (reset),
    .in    (in_beats),
    .psums (psums)
  );

  kernel_reducer reducer (
    .clk     (clk),
    .reset   (reset),
    .psums   (psums),
    .results (results)
  );

  beat_fifo #(.T(conv_data_pkg::result_t)) out_fifo (
    .clk   (clk),
    .reset (reset),
    .in    (results),
    .out   (out_res)
  );

endmodule

/* design/conv_mac_array.sv */
/*
  Multiply-accumulate over UNITS x MEMBERS lanes, one beat per cycle.
  The first beat after reset or after a cin_last beat starts a new run.
  Only one finished run is held; a stalled output stalls the input.
*/
module conv_mac_array (
  input  logic  clk,
  input  logic  reset,
  stream_if.dst in,
  stream_if.src psums
);

  conv_data_pkg::member_sums_t acc;
  conv_data_pkg::member_sums_t acc_next;
  conv_data_pkg::psum_t        psum_q;
  logic                        psum_valid;
  logic                        run_open;
  logic                        accept;
  logic                        run_done;

  // ========================================
  // handshake
  // ========================================
  assign in.ready = !psum_valid || psums.ready;
  assign accept   = in.valid && in.ready;
  assign run_done = accept && in.data.side.cin_last;

  assign psums.valid = psum_valid;
  assign psums.data  = psum_q;

  // ========================================
  // products and running sums
  // ========================================
  always_comb begin
    logic signed [2*conv_data_pkg::WORD_WIDTH-1:0] prod;
    prod = '0;
    for (int u = 0; u < conv_data_pkg::UNITS; u++) begin
      for (int m = 0; m < conv_data_pkg::MEMBERS; m++) begin
        prod = in.data.pixels[u] * in.data.weights[m];
        // a closed run is dropped here instead of cleared at cin_last.
        acc_next[u][m] = (run_open ? acc[u][m] : '0) + conv_data_pkg::acc_t'(prod);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      acc <= acc_next;
    end
    if (run_done) begin
      psum_q.sums <= acc_next;
      psum_q.kw   <= in.data.side.kw;
      psum_q.last <= in.data.side.last;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      run_open   <= 1'b0;
      psum_valid <= 1'b0;
    end else begin
      if (accept) begin
        run_open <= !in.data.side.cin_last;
      end
      if (run_done) begin
        psum_valid <= 1'b1;
      end else if (psums.ready) begin
        psum_valid <= 1'b0;
      end
    end
  end

  // kw travels from the top ports through the input FIFO.
  a_kw_legal: assert property (
    @(posedge clk) disable iff (reset)
    accept |-> (in.data.side.kw != '0)
  ) else $error("conv_mac_array: illegal kernel width code 0");

endmodule

/* design/kernel_reducer.sv */
/*
  One-entry register stage that adds kernel-width groups of members.
  Group slots above group_count(kw) are zero with their keep bit clear.
*/
module kernel_reducer (
  input  logic  clk,
  input  logic  reset,
  stream_if.dst psums,
  stream_if.src results
);

  conv_data_pkg::result_t res_next;
  conv_data_pkg::result_t res_q;
  logic                   res_valid;
  logic                   take;

  assign psums.ready   = results.ready || !res_valid;
  assign take          = psums.valid && psums.ready;
  assign results.valid = res_valid;
  assign results.data  = res_q;

  // ========================================
  // group sums
  // ========================================
  always_comb begin
    int unsigned kw_w;
    int unsigned n_groups;
    int unsigned m;
    kw_w     = conv_cfg_pkg::kw_width(psums.data.kw);
    n_groups = conv_cfg_pkg::group_count(conv_data_pkg::MEMBERS, psums.data.kw);
    m        = 0;
    res_next = '0;
    res_next.last = psums.data.last;
    for (int unsigned g = 0; g < conv_data_pkg::GROUPS_MAX; g++) begin
      if (g < n_groups) begin
        res_next.keep[g] = 1'b1;
        for (int u = 0; u < conv_data_pkg::UNITS; u++) begin
          for (int unsigned k = 0; k < conv_cfg_pkg::KW_MAX; k++) begin
            if (k < kw_w) begin
              m = g * kw_w + k;
              res_next.sums[u][g] = res_next.sums[u][g] + psums.data.sums[u][m];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      res_q <= res_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      res_valid <= 1'b0;
    end else if (take) begin
      res_valid <= 1'b1;
    end else if (results.ready) begin
      res_valid <= 1'b0;
    end
  end

  // the array must keep its kw steady until the stall ends.
  a_kw_stable: assert property (
    @(posedge clk) disable iff (reset)
    psums.valid && !psums.ready |=> $stable(psums.data.kw)
  ) else $error("kernel_reducer: kw changed while psums stalled");

endmodule

/* design/stream_if.sv */
/*
  Valid/ready stream carrying one payload of type T per transfer.
  A source holds valid and data until ready is seen high at a clock edge.
*/
interface stream_if #(
  parameter type T = logic
);

  logic valid;
  logic ready;
  T     data;

  // producer side.
  modport src (
    output valid,
    output data,
    input  ready
  );

  // consumer side.
  modport dst (
    input  valid,
    input  data,
    output ready
  );

endinterface

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_conv_engine -f sim.f -o tb_conv_engine_sim

output=$(./obj_dir/tb_conv_engine_sim 2>&1) || true
echo "$output"

if grep -q "All tests passed!" <<< "$output"; then
  exit 0
else
  exit 1
fi

/* sim.f */
design/conv_cfg_pkg.sv
design/conv_data_pkg.sv
design/stream_if.sv
design/beat_fifo.sv
design/conv_mac_array.sv
design/kernel_reducer.sv
design/conv_engine_top.sv
tb/tb_conv_engine.sv

/* tb/conv_stimulus.txt */
# B kw cin_last last pixel0 pixel1 weight0 weight1 weight2 weight3 weight4 weight5
# E unit0 sums g0..g5, unit1 sums g0..g5, keep as binary g5..g0, last
B 1 1 0 2 3 1 2 3 4 5 6
E 2 4 6 8 10 12 3 6 9 12 15 18 111111 0
B 1 1 0 -1 5 7 -2 0 3 -4 1
E -7 2 0 -3 4 -1 35 -10 0 15 -20 5 111111 0
B 1 0 0 1 2 1 1 1 1 1 1
B 1 0 0 3 -1 2 0 1 0 -1 4
B 1 1 0 2 2 0 5 0 -5 1 1
E 7 11 4 -9 0 15 0 12 1 -8 5 0 111111 0
B 1 1 0 1 1 1 2 3 4 5 6
E 1 2 3 4 5 6 1 2 3 4 5 6 111111 0
B 3 1 0 2 -3 1 2 3 4 5 6
E 12 30 0 0 0 0 -18 -45 0 0 0 0 000011 0
B 2 1 0 4 1 1 -1 2 2 -3 5
E 0 16 8 0 0 0 0 4 2 0 0 0 000111 0
B 2 0 0 -128 -7 -128 127 -1 -50 100 -100
B 2 1 0 127 -128 -128 -128 -128 -128 -128 -128
E -32384 -25984 -32512 0 0 0 32775 33125 32768 0 0 0 000111 0
B 3 1 0 1 -1 10 20 30 -5 -5 -5
E 60 -15 0 0 0 0 -60 15 0 0 0 0 000011 0
B 1 1 0 -2 0 3 3 3 3 3 3
E -6 -6 -6 -6 -6 -6 0 0 0 0 0 0 111111 0
B 2 1 1 5 6 1 2 3 4 5 6
E 15 35 55 0 0 0 18 42 66 0 0 0 000111 1
B 3 0 0 3 2 1 1 1 1 1 1
B 3 1 1 -1 4 2 2 2 -2 -2 -2
E 3 15 0 0 0 0 30 -18 0 0 0 0 000011 1

/* tb/tb_conv_engine.sv */
/*
  Testbench for conv_engine_top. Beats and expected results are read from
  tb/conv_stimulus.txt, so the simulation must run from the project root.
  m_ready is throttled by an LCG, and the first mismatch ends the run.
*/
module tb_conv_engine;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD = 20;
  localparam int          DRIVE_SKEW = 2;
  localparam logic [31:0] LCG_SEED   = 32'he86e_7d6c;

  logic                                 clk;
  logic                                 reset;
  logic                                 s_valid;
  logic                                 s_ready;
  conv_data_pkg::pixels_t               s_pixels;
  conv_data_pkg::weights_t              s_weights;
  conv_cfg_pkg::kw_t                    s_kw;
  logic                                 s_cin_last;
  logic                                 s_last;
  logic                                 m_valid;
  logic                                 m_ready;
  conv_data_pkg::group_sums_t           m_data;
  logic [conv_data_pkg::GROUPS_MAX-1:0] m_keep;
  logic                                 m_last;

  conv_data_pkg::beat_t   beat_q[$];
  conv_data_pkg::result_t want_q[$];
  int                     cycle_count = 0;
  int                     cycle_limit = 0;
  logic [31:0]            lcg_state;

  conv_engine_top conv_engine_top_inst (
    .clk        (clk),
    .reset      (reset),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .s_pixels   (s_pixels),
    .s_weights  (s_weights),
    .s_kw       (s_kw),
    .s_cin_last (s_cin_last),
    .s_last     (s_last),
    .m_valid    (m_valid),
    .m_ready    (m_ready),
    .m_data     (m_data),
    .m_keep     (m_keep),
    .m_last     (m_last)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // ========================================
  // helpers
  // ========================================
  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic compare_result(input conv_data_pkg::result_t got,
                                input conv_data_pkg::result_t want);
    for (int u = 0; u < conv_data_pkg::UNITS; u++) begin
      for (int g = 0; g < conv_data_pkg::GROUPS_MAX; g++) begin
        if (got.sums[u][g] !== want.sums[u][g]) begin
          $display("Error at %0d ns: unit %0d group %0d sum is %0d, expected %0d",
                   $time, u, g, got.sums[u][g], want.sums[u][g]);
          abort_run();
        end
      end
    end
  endtask

  task automatic compare_keep(input logic [conv_data_pkg::GROUPS_MAX-1:0] got,
                              input logic [conv_data_pkg::GROUPS_MAX-1:0] want);
    if (got !== want) begin
      $display("Error at %0d ns: keep is %b, expected %b", $time, got, want);
      abort_run();
    end
  endtask

  task automatic compare_last(input logic got, input logic want);
    if (got !== want) begin
      $display("Error at %0d ns: last is %b, expected %b", $time, got, want);
      abort_run();
    end
  endtask

  // lines that start with neither B nor E are comments or blank.
  task automatic load_stimulus();
    int                                   fd;
    int                                   n;
    int                                   v[14];
    string                                line;
    logic [conv_data_pkg::GROUPS_MAX-1:0] keep;
    conv_data_pkg::beat_t                 beat;
    conv_data_pkg::result_t               want;
    fd = $fopen("tb/conv_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file tb/conv_stimulus.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 0 && line.getc(0) == "B") begin
        n = $sscanf(line, "B %d %d %d %d %d %d %d %d %d %d %d", v[0], v[1], v[2],
                    v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
        if (n != 11) begin
          $display("A beat record in the stimulus file is malformed");
          abort_run();
        end
        beat.side.kw       = conv_cfg_pkg::kw_t'(v[0]);
        beat.side.cin_last = (v[1] != 0);
        beat.side.last     = (v[2] != 0);
        for (int u = 0; u < conv_data_pkg::UNITS; u++) begin
          beat.pixels[u] = conv_data_pkg::word_t'(v[3+u]);
        end
        for (int m = 0; m < conv_data_pkg::MEMBERS; m++) begin
          beat.weights[m] = conv_data_pkg::word_t'(v[5+m]);
        end
        beat_q.push_back(beat);
      end else if (line.len() > 0 && line.getc(0) == "E") begin
        n = $sscanf(line, "E %d %d %d %d %d %d %d %d %d %d %d %d %b %d", v[0], v[1],
                    v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                    keep, v[12]);
        if (n != 14) begin
          $display("An expected-result record in the stimulus file is malformed");
          abort_run();
        end
        for (int u = 0; u < conv_data_pkg::UNITS; u++) begin
          for (int g = 0; g < conv_data_pkg::GROUPS_MAX; g++) begin
            want.sums[u][g] = conv_data_pkg::acc_t'(v[u*conv_data_pkg::GROUPS_MAX+g]);
          end
        end
        want.keep = keep;
        want.last = (v[12] != 0);
        want_q.push_back(want);
      end
    end
    $fclose(fd);
  endtask

  task automatic send_beat(input conv_data_pkg::beat_t beat);
    s_valid    = 1'b1;
    s_pixels   = beat.pixels;
    s_weights  = beat.weights;
    s_kw       = beat.side.kw;
    s_cin_last = beat.side.cin_last;
    s_last     = beat.side.last;
    // s_ready only moves at a rising edge, so the negedge value decides the transfer.
    @(negedge clk);
    while (!s_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
    #DRIVE_SKEW;
  endtask

  // ========================================
  // stimulus, back-pressure and checking
  // ========================================
  initial begin
    reset      = 1'b1;
    s_valid    = 1'b0;
    s_pixels   = '0;
    s_weights  = '0;
    s_kw       = conv_cfg_pkg::kw_t'(1);
    s_cin_last = 1'b0;
    s_last     = 1'b0;
    load_stimulus();
    cycle_limit = 40 * (beat_q.size() + want_q.size());
    repeat (2) @(posedge clk);
    #DRIVE_SKEW;
    reset = 1'b0;
    for (int i = 0; i < beat_q.size(); i++) begin
      send_beat(beat_q[i]);
    end
    s_valid = 1'b0;
    while (want_q.size() != 0) begin
      @(posedge clk);
    end
    $display("All tests passed!");
    $finish;
  end

  // about three ready cycles in four.
  initial begin
    m_ready   = 1'b0;
    lcg_state = LCG_SEED;
    forever begin
      @(posedge clk);
      #DRIVE_SKEW;
      lcg_state = lcg_next(lcg_state);
      m_ready   = (lcg_state[31:30] != 2'b00);
    end
  end

  always @(negedge clk) begin : monitor
    conv_data_pkg::result_t got;
    conv_data_pkg::result_t want;
    if (!reset && m_valid && m_ready) begin
      if (want_q.size() == 0) begin
        $display("The DUT sent a result that was not expected");
        abort_run();
      end
      want     = want_q.pop_front();
      got.sums = m_data;
      got.keep = m_keep;
      got.last = m_last;
      compare_result(got, want);
      compare_keep(got.keep, want.keep);
      compare_last(got.last, want.last);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the expected results never arrived within %0d cycles", cycle_limit);
      abort_run();
    end
  end

endmodule
